// File: rtl/emesh_pkg.sv
// Shared packet, data-mode and memory-word types; imported by every emesh memory module
package emesh_pkg;

   // Packet address and data widths
   localparam int emesh_aw = 32;
   localparam int emesh_dw = 32;

   // Byte lanes in one 64-bit RAM word
   localparam int mem_lanes = 8;

   // Access size of a request
   typedef enum logic [1:0] {
      mode_byte   = 2'd0,
      mode_short  = 2'd1,
      mode_word   = 2'd2,
      mode_double = 2'd3
   } emesh_mode_e;

   // Mesh packet, 103 bits, write flag on top
   typedef struct packed {
      logic                write;
      emesh_mode_e         datamode;
      logic [3:0]          ctrlmode;
      logic [emesh_aw-1:0] dstaddr;
      // Lower half of a double write
      logic [emesh_dw-1:0] data;
      // Upper half of a double write, return address of a read
      logic [emesh_aw-1:0] srcaddr;
   } emesh_packet_t;

   // Two 32-bit halves of a RAM word
   typedef struct packed {
      logic [emesh_dw-1:0] hi;
      logic [emesh_dw-1:0] lo;
   } mem_half_t;

   // One RAM word
   // Byte view for lane writes, half view for packet data
   typedef union packed {
      logic [mem_lanes-1:0][7:0] bytes;
      mem_half_t                 half;
   } mem_word_t;

endpackage

// File: rtl/emesh_lane_decode.sv
// Request decoder for the emesh memory; turns one packet into RAM controls and read strobe
`timescale 1ns/1ps

module emesh_lane_decode
   import emesh_pkg::*;
#(
   // Word-address bits of the RAM
   parameter int mem_aw = 10
)(
   input  logic                 access_in,
   input  logic                 wait_in,
   input  emesh_packet_t        req,
   output logic                 en,
   output logic [mem_lanes-1:0] wen,
   output logic [mem_aw-1:0]    addr,
   output mem_word_t            din,
   output logic                 rd_take,
   output logic                 wait_out
);

   logic wr_take;

   // Reads wait for the return path, writes never do
   assign rd_take  = access_in & ~req.write & ~wait_in;
   assign wr_take  = access_in & req.write;
   assign en       = rd_take | wr_take;

   // Only a read that is actually held pushes back
   assign wait_out = access_in & ~req.write & wait_in;

   // 64-bit words, so byte offset bits are dropped
   assign addr = req.dstaddr[mem_aw+2:3];

   // Byte-lane mask
   // Write flag, mode, then low address bits; all zero for reads
   always_comb
   begin
      priority casez ({req.write, req.datamode, req.dstaddr[2:0]})
         {1'b1, mode_byte, 3'd0}:     wen = 8'h01;
         {1'b1, mode_byte, 3'd1}:     wen = 8'h02;
         {1'b1, mode_byte, 3'd2}:     wen = 8'h04;
         {1'b1, mode_byte, 3'd3}:     wen = 8'h08;
         {1'b1, mode_byte, 3'd4}:     wen = 8'h10;
         {1'b1, mode_byte, 3'd5}:     wen = 8'h20;
         {1'b1, mode_byte, 3'd6}:     wen = 8'h40;
         {1'b1, mode_byte, 3'd7}:     wen = 8'h80;
         // Short ignores address bit 0
         {1'b1, mode_short, 3'b00?}:  wen = 8'h03;
         {1'b1, mode_short, 3'b01?}:  wen = 8'h0c;
         {1'b1, mode_short, 3'b10?}:  wen = 8'h30;
         {1'b1, mode_short, 3'b11?}:  wen = 8'hc0;
         // Word picks a half by bit 2
         {1'b1, mode_word, 3'b0??}:   wen = 8'h0f;
         {1'b1, mode_word, 3'b1??}:   wen = 8'hf0;
         {1'b1, mode_double, 3'b???}: wen = 8'hff;
         default:                     wen = 8'h00;
      endcase
   end

   // Write word
   // Double carries its upper half in srcaddr
   // Smaller sizes copy data to both halves so any lane finds its bits
   always_comb
   begin
      if (req.datamode == mode_double)
      begin
         din.half.hi = req.srcaddr;
         din.half.lo = req.data;
      end
      else
      begin
         din.half.hi = req.data;
         din.half.lo = req.data;
      end
   end

endmodule

// File: rtl/mem_sp.sv
// Single-port synchronous RAM with byte write enables; stand-in for the memory macro
`timescale 1ns/1ps

module mem_sp
   import emesh_pkg::*;
#(
   // Word-address bits
   parameter int mem_aw = 10
)(
   input  logic                 clk,
   input  logic                 en,
   input  logic [mem_lanes-1:0] wen,
   input  logic [mem_aw-1:0]    addr,
   input  mem_word_t            din,
   output mem_word_t            dout
);

   // Storage array, contents undefined until written
   mem_word_t ram [0:(1<<mem_aw)-1];

   // Lane-wise write and registered read on the same enable
   always_ff @(posedge clk)
   begin
      if (en)
      begin
         for (int i = 0; i < mem_lanes; i++)
         begin
            if (wen[i])
            begin
               ram[addr].bytes[i] <= din.bytes[i];
            end
         end
         // Read data one cycle after the taking edge
         dout <= ram[addr];
      end
   end

endmodule

// File: rtl/emesh_read_return.sv
// Read-return stage; registers read fields and builds the response packet from RAM data
`timescale 1ns/1ps

module emesh_read_return
   import emesh_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          rd_take,
   input  emesh_packet_t req,
   input  mem_word_t     dout,
   output logic          access_out,
   output emesh_packet_t packet_out
);

   // Fields kept from the taken read
   logic                half_sel_q;
   emesh_mode_e         datamode_q;
   logic [3:0]          ctrlmode_q;
   logic [emesh_aw-1:0] retaddr_q;

   // One pulse per taken read, next cycle
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         access_out <= 1'b0;
      end
      else
      begin
         access_out <= rd_take;
      end
   end

   // Payload capture
   always_ff @(posedge clk)
   begin
      if (rd_take)
      begin
         half_sel_q <= req.dstaddr[2];
         datamode_q <= req.datamode;
         ctrlmode_q <= req.ctrlmode;
         // Response goes back to the requester
         retaddr_q  <= req.srcaddr;
      end
   end

   // Response packet, valid while access_out is high
   always_comb
   begin
      packet_out.write    = 1'b1;
      packet_out.datamode = datamode_q;
      packet_out.ctrlmode = ctrlmode_q;
      packet_out.dstaddr  = retaddr_q;
      packet_out.data     = half_sel_q ? dout.half.hi : dout.half.lo;
      // Upper half always rides in srcaddr
      packet_out.srcaddr  = dout.half.hi;
   end

endmodule

// File: rtl/emesh_memory.sv
// Top of the byte-addressable 64-bit emesh memory endpoint; connects decode, RAM and return
`timescale 1ns/1ps

module emesh_memory
   import emesh_pkg::*;
#(
   // Word-address bits, 8 bytes per word
   parameter int mem_aw = 10
)(
   input  logic          clk,
   input  logic          arst_n,
   // Requests from the mesh
   input  logic          access_in,
   input  emesh_packet_t packet_in,
   output logic          wait_out,
   // Read returns to the mesh
   output logic          access_out,
   output emesh_packet_t packet_out,
   input  logic          wait_in
);

   // RAM controls
   logic                 en;
   logic [mem_lanes-1:0] wen;
   logic [mem_aw-1:0]    addr;
   mem_word_t            din;
   mem_word_t            dout;

   // Read accepted this cycle
   logic                 rd_take;

   // Request decode and back-pressure
   emesh_lane_decode #(
      .mem_aw   (mem_aw)
   ) u_decode (
      .access_in (access_in),
      .wait_in   (wait_in),
      .req       (packet_in),
      .en        (en),
      .wen       (wen),
      .addr      (addr),
      .din       (din),
      .rd_take   (rd_take),
      .wait_out  (wait_out)
   );

   // Storage
   mem_sp #(
      .mem_aw (mem_aw)
   ) u_mem (
      .clk  (clk),
      .en   (en),
      .wen  (wen),
      .addr (addr),
      .din  (din),
      .dout (dout)
   );

   // Response one cycle after each taken read
   emesh_read_return u_return (
      .clk        (clk),
      .arst_n     (arst_n),
      .rd_take    (rd_take),
      .req        (packet_in),
      .dout       (dout),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// File: sim/emesh_mem_model.svh
// Reference memory model for the emesh testbench; include inside the module after the import
`ifndef EMESH_MEM_MODEL_SVH
`define EMESH_MEM_MODEL_SVH

// Modelled word-address bits, matches the DUT setting
localparam int model_aw = 6;

// Model storage and expected read returns, oldest first
mem_word_t     model_mem [0:(1<<model_aw)-1];
emesh_packet_t model_expect_q [$];

// Lanes written for a request, by size and low address bits
function automatic logic [mem_lanes-1:0] model_lane_mask(emesh_packet_t p);
   logic [mem_lanes-1:0] mask;
   case (p.datamode)
      mode_byte:  mask = 8'b0000_0001 << p.dstaddr[2:0];
      mode_short: mask = 8'b0000_0011 << {p.dstaddr[2:1], 1'b0};
      mode_word:  mask = 8'b0000_1111 << {p.dstaddr[2], 2'b00};
      default:    mask = 8'hff;
   endcase
   return mask;
endfunction

// Write word, double splits across srcaddr and data
function automatic mem_word_t model_write_word(emesh_packet_t p);
   mem_word_t w;
   w.half.hi = (p.datamode == mode_double) ? p.srcaddr : p.data;
   w.half.lo = p.data;
   return w;
endfunction

// Apply one taken write at the DUT's edge
function automatic void model_write(emesh_packet_t p);
   logic [mem_lanes-1:0] mask;
   mem_word_t            w;
   logic [model_aw-1:0]  idx;
   mask = model_lane_mask(p);
   w    = model_write_word(p);
   idx  = p.dstaddr[model_aw+2:3];
   for (int i = 0; i < mem_lanes; i++)
   begin
      if (mask[i])
      begin
         model_mem[idx].bytes[i] = w.bytes[i];
      end
   end
endfunction

// Queue the expected return of one taken read
function automatic void model_read(emesh_packet_t p);
   emesh_packet_t r;
   mem_word_t     w;
   w          = model_mem[p.dstaddr[model_aw+2:3]];
   r.write    = 1'b1;
   r.datamode = p.datamode;
   r.ctrlmode = p.ctrlmode;
   r.dstaddr  = p.srcaddr;
   r.data     = p.dstaddr[2] ? w.half.hi : w.half.lo;
   r.srcaddr  = w.half.hi;
   model_expect_q.push_back(r);
endfunction

`endif

// File: sim/tb_emesh_memory.sv
// Self-checking testbench for the emesh memory; random requests checked against an included model
`timescale 1ns/1ps

module tb_emesh_memory
   import emesh_pkg::*;
();

   // Model array, lane rule and expected returns
   `include "emesh_mem_model.svh"

   localparam int clk_period = 4;
   localparam int n_sub      = 120;
   localparam int n_b2b      = 40;
   localparam int n_bp       = 150;
   localparam int n_mix      = 400;
   // Reset, fill, sub-word, word reads, pairs, back-pressure, mixed, idles
   localparam int total_cycles = 5 + 128 + (n_sub + 64) + 64 + 2 * n_b2b
                               + (n_bp + 64) + n_mix + 40;
   localparam int margin_cycles = 100;

   logic          clk;
   logic          arst_n;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;

   // Checker state
   logic        pending;
   int          checks;
   int          value_errors;
   int          resp_errors;
   logic [31:0] rng_state;

   emesh_memory #(
      .mem_aw (model_aw)
   ) dut0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(clk_period / 2) clk = ~clk;
      end
   end

   // LCG step with the upper state bits swapped down
   function automatic logic [31:0] rand_u32();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return {rng_state[15:0], rng_state[31:16]};
   endfunction

   function automatic int rand_pct();
      return int'(rand_u32() % 32'd100);
   endfunction

   // Request with random ctrlmode, data and return address
   function automatic emesh_packet_t make_req(logic wr, emesh_mode_e mode, logic [31:0] addr);
      emesh_packet_t p;
      logic [31:0]   r;
      r          = rand_u32();
      p.write    = wr;
      p.datamode = mode;
      p.ctrlmode = r[3:0];
      p.dstaddr  = addr;
      p.data     = rand_u32();
      p.srcaddr  = rand_u32();
      return p;
   endfunction

   // Byte address inside the modelled words
   function automatic logic [31:0] rand_addr();
      logic [31:0] r;
      r = rand_u32();
      return {23'd0, r[8:0]};
   endfunction

   task automatic compare_packet(emesh_packet_t got, emesh_packet_t exp, string what);
      checks++;
      if (got !== exp)
      begin
         value_errors++;
         $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_level(logic got, logic exp, string what);
      checks++;
      if (got !== exp)
      begin
         value_errors++;
         $display("Fail %0t ns: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Response for the read taken last cycle
   task automatic check_response();
      emesh_packet_t exp;
      if (pending && !access_out)
      begin
         resp_errors++;
         $display("Missing read response at %0t ns", $time);
         exp = model_expect_q.pop_front();
      end
      else if (!pending && access_out)
      begin
         resp_errors++;
         $display("Unexpected read response at %0t ns", $time);
      end
      else if (pending)
      begin
         exp = model_expect_q.pop_front();
         compare_packet(packet_out, exp, "read return");
      end
      pending = 1'b0;
   endtask

   // Mid-cycle sampling with inputs and outputs settled
   always @(negedge clk)
   begin
      if (!arst_n)
      begin
         compare_level(access_out, 1'b0, "access_out in reset");
         pending = 1'b0;
      end
      else
      begin
         check_response();
         compare_level(wait_out, access_in & ~packet_in.write & wait_in, "wait_out");
         // Same taking rule as the DUT edge that follows
         if (access_in && packet_in.write)
         begin
            model_write(packet_in);
         end
         else if (access_in && !wait_in)
         begin
            model_read(packet_in);
            pending = 1'b1;
         end
      end
   end

   task automatic issue(emesh_packet_t p, logic wt);
      @(posedge clk);
      access_in <= 1'b1;
      packet_in <= p;
      wait_in   <= wt;
   endtask

   task automatic idle(int n);
      repeat (n)
      begin
         @(posedge clk);
         access_in <= 1'b0;
         wait_in   <= 1'b0;
      end
   endtask

   // Double read of every word with the lower half selected
   task automatic read_all();
      for (int i = 0; i < 64; i++)
      begin
         issue(make_req(1'b0, mode_double, i * 8), 1'b0);
      end
   endtask

   // One random cycle; a held read stays on the bus
   task automatic random_cycle(int access_pct, int write_pct, int wait_pct);
      logic        held;
      logic        wt;
      logic [31:0] r;
      @(posedge clk);
      held = access_in && !packet_in.write && wait_in;
      wt   = rand_pct() < wait_pct;
      r    = rand_u32();
      if (held)
      begin
         wait_in <= wt;
      end
      else if (rand_pct() < access_pct)
      begin
         access_in <= 1'b1;
         packet_in <= make_req(rand_pct() < write_pct, emesh_mode_e'(r[1:0]), rand_addr());
         wait_in   <= wt;
      end
      else
      begin
         access_in <= 1'b0;
         wait_in   <= wt;
      end
   endtask

   initial
   begin
      #((total_cycles + margin_cycles) * clk_period);
      $display("Watchdog timeout, the run did not finish in time");
      $display("sim failed");
      $finish;
   end

   initial
   begin
      logic [31:0]   a;
      logic [31:0]   r;
      emesh_mode_e   m;
      rng_state    = 32'd45665;
      checks       = 0;
      value_errors = 0;
      resp_errors  = 0;
      pending      = 1'b0;
      arst_n       = 1'b0;
      access_in    = 1'b0;
      wait_in      = 1'b0;
      packet_in    = '0;
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;

      // Fill every word and read it back
      for (int i = 0; i < 64; i++)
      begin
         issue(make_req(1'b1, mode_double, i * 8), 1'b0);
      end
      read_all();
      idle(4);

      // Byte, short and word writes at any offset
      for (int i = 0; i < n_sub; i++)
      begin
         r = rand_u32();
         m = emesh_mode_e'(r[1:0] % 3);
         issue(make_req(1'b1, m, rand_addr()), 1'b0);
      end
      read_all();
      idle(4);

      // Word reads with the half picked by bit 2
      for (int i = 0; i < 64; i++)
      begin
         r = rand_u32();
         issue(make_req(1'b0, mode_word, {23'd0, i[5:0], r[0], 2'b00}), 1'b0);
      end
      idle(4);

      // Write followed at once by a read of the same word
      for (int i = 0; i < n_b2b; i++)
      begin
         r = rand_u32();
         a = rand_addr();
         issue(make_req(1'b1, emesh_mode_e'(r[1:0]), a), 1'b0);
         issue(make_req(1'b0, emesh_mode_e'(r[3:2]), a), 1'b0);
      end
      idle(4);

      // Heavy wait_in while writes still land
      for (int i = 0; i < n_bp; i++)
      begin
         random_cycle(80, 50, 50);
      end
      idle(2);
      read_all();
      idle(4);

      // Mixed traffic
      for (int i = 0; i < n_mix; i++)
      begin
         random_cycle(70, 40, 25);
      end
      idle(4);

      if (pending || model_expect_q.size() != 0)
      begin
         resp_errors++;
         $display("Read responses still outstanding at the end of the run");
      end
      $display("checks %0d, value errors %0d, response errors %0d",
               checks, value_errors, resp_errors);
      if (value_errors == 0 && resp_errors == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: emesh_memory.f
+incdir+sim
rtl/emesh_pkg.sv
rtl/emesh_lane_decode.sv
rtl/mem_sp.sv
rtl/emesh_read_return.sv
rtl/emesh_memory.sv
sim/tb_emesh_memory.sv

// File: Bender.yml
package:
  name: emesh_memory

sources:
  # Design, package first
  - rtl/emesh_pkg.sv
  - rtl/emesh_lane_decode.sv
  - rtl/mem_sp.sv
  - rtl/emesh_read_return.sv
  - rtl/emesh_memory.sv

  # Testbench with its model header
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_emesh_memory.sv
